// File: daq_pkg.sv
// widths, register map, mode and chip-select codes, fsm state enums
package daq_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths with a meaning
  typedef logic [31:0] reg_word_t;   // one spi register
  typedef logic [6:0]  reg_addr_t;
  typedef logic [2:0]  cs_vec_t;     // board chip-select vector
  typedef logic [2:0]  mode_t;       // operating mode in cr[2:0]
  typedef logic [5:0]  seq_entry_t;  // {pc_sw[1:0], azmux[3:0]}
  typedef logic [2:0]  seq_idx_t;
  typedef logic [23:0] count_t;      // clk counts
  typedef logic [25:0] out_vec_t;    // muxed board pins

  // chip-select codes
  localparam cs_vec_t CS_DEASSERT   = 3'd0;
  localparam cs_vec_t CS_FPGA0      = 3'd1;  // our own register set
  localparam cs_vec_t CS_4094       = 3'd2;
  localparam cs_vec_t CS_INVERT_DAC = 3'd3;
  localparam cs_vec_t CS_MDAC1      = 3'd4;

  // operating modes, everything else drives zeros
  localparam mode_t MODE_DIRECT  = 3'd0;
  localparam mode_t MODE_SA_MOCK = 3'd6;   // sequencer against mock adc

  //////////////////////////////////////////////////////////////////////
  // register map
  localparam reg_addr_t ADDR_CR           = 7'd0;   // mode in [2:0]
  localparam reg_addr_t ADDR_DIRECT       = 7'd1;
  localparam reg_addr_t ADDR_4094_OE      = 7'd2;
  localparam reg_addr_t ADDR_STATUS       = 7'd3;   // read only
  localparam reg_addr_t ADDR_SA_PRECHARGE = 7'd4;
  localparam reg_addr_t ADDR_SA_SEQ_N     = 7'd5;
  localparam reg_addr_t ADDR_SA_SEQ0      = 7'd6;
  localparam reg_addr_t ADDR_SA_SEQ1      = 7'd7;
  localparam reg_addr_t ADDR_SA_SEQ2      = 7'd8;
  localparam reg_addr_t ADDR_SA_SEQ3      = 7'd9;
  localparam reg_addr_t ADDR_ADC_APERTURE = 7'd10;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;
  localparam int         NUM_SEQ      = 4;     // programmable entries

  // fsm states
  typedef enum logic [1:0] {IDLE, PRECHARGE, MEASURE, ADVANCE} sa_state_t;
  typedef enum logic {ADDR, DATA} spi_state_t;

endpackage

// File: register_set.sv
// oversampled spi slave with the writable and readable register file
`timescale 1ns/1ps

module register_set import daq_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      sck_i,
  input  logic      sdi_i,
  input  logic      sel_i,          // fpga selected, active high
  input  reg_word_t reg_status_i,
  output logic      sdo_o,
  output reg_word_t reg_cr_o,
  output reg_word_t reg_direct_o,
  output reg_word_t reg_4094_oe_o,
  output reg_word_t reg_sa_precharge_o,
  output reg_word_t reg_sa_seq_n_o,
  output reg_word_t reg_sa_seq0_o,
  output reg_word_t reg_sa_seq1_o,
  output reg_word_t reg_sa_seq2_o,
  output reg_word_t reg_sa_seq3_o,
  output reg_word_t reg_adc_aperture_o
);

  localparam logic [5:0] HDR_LAST   = 6'd7;    // flag + 7 addr bits
  localparam logic [5:0] FRAME_BITS = 6'd40;

  logic [2:0] sck_q;        // 2 sync flops + edge detect
  logic [1:0] sdi_q;
  logic [2:0] sel_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       sdi_s;
  logic       sel_s;
  logic       sel_fall;     // end of frame

  spi_state_t spi_state;
  logic [5:0] bit_cnt;
  logic       hdr_done;
  logic       wr_flag;
  reg_addr_t  addr;
  reg_addr_t  hdr_addr;
  reg_word_t  in_sr;        // mosi shift
  reg_word_t  rd_sr;        // miso shift
  reg_word_t  rd_word;
  logic       sdo_q;

  //////////////////////////////////////////////////////////////////////
  // synchronizers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sck_q <= '0;
      sdi_q <= '0;
      sel_q <= '0;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      sdi_q <= {sdi_q[0], sdi_i};
      sel_q <= {sel_q[1:0], sel_i};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign sdi_s    = sdi_q[1];
  assign sel_s    = sel_q[1];
  assign sel_fall = ~sel_q[1] & sel_q[2];

  // header complete on this sck edge
  assign hdr_done = sck_rise && (spi_state == ADDR) && (bit_cnt == HDR_LAST);
  assign hdr_addr = {in_sr[5:0], sdi_s};   // last addr bit arriving now

  // frame control, cleared whenever deselected
  always_ff @(posedge clk_i) begin
    if (rst_i || !sel_s) begin
      spi_state <= ADDR;
      bit_cnt   <= '0;
      sdo_q     <= 1'b0;
    end else begin
      if (sck_rise && bit_cnt != FRAME_BITS) bit_cnt <= bit_cnt + 6'd1;
      if (hdr_done) spi_state <= DATA;
      if (sck_fall && spi_state == DATA) sdo_q <= rd_sr[31];   // msb first
    end
  end

  // shift registers
  always_ff @(posedge clk_i) begin
    if (sck_rise && sel_s) in_sr <= {in_sr[30:0], sdi_s};
    if (hdr_done) begin
      wr_flag <= in_sr[6];
      addr    <= hdr_addr;
      rd_sr   <= rd_word;                          // snapshot for read
    end else if (sck_fall && sel_s && spi_state == DATA) begin
      rd_sr <= {rd_sr[30:0], 1'b0};
    end
  end

  // read mux on the incoming address
  always_comb begin
    case (hdr_addr)
      ADDR_CR:           rd_word = reg_cr_o;
      ADDR_DIRECT:       rd_word = reg_direct_o;
      ADDR_4094_OE:      rd_word = reg_4094_oe_o;
      ADDR_STATUS:       rd_word = reg_status_i;
      ADDR_SA_PRECHARGE: rd_word = reg_sa_precharge_o;
      ADDR_SA_SEQ_N:     rd_word = reg_sa_seq_n_o;
      ADDR_SA_SEQ0:      rd_word = reg_sa_seq0_o;
      ADDR_SA_SEQ1:      rd_word = reg_sa_seq1_o;
      ADDR_SA_SEQ2:      rd_word = reg_sa_seq2_o;
      ADDR_SA_SEQ3:      rd_word = reg_sa_seq3_o;
      ADDR_ADC_APERTURE: rd_word = reg_adc_aperture_o;
      default:           rd_word = '0;             // unmapped reads as 0
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // commit on select release, full frames only
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_cr_o           <= '0;
      reg_direct_o       <= '0;
      reg_4094_oe_o      <= '0;   // 4094 outputs disabled at start up
      reg_sa_precharge_o <= '0;
      reg_sa_seq_n_o     <= '0;
      reg_sa_seq0_o      <= '0;
      reg_sa_seq1_o      <= '0;
      reg_sa_seq2_o      <= '0;
      reg_sa_seq3_o      <= '0;
      reg_adc_aperture_o <= '0;
    end else if (sel_fall && bit_cnt == FRAME_BITS && wr_flag) begin
      case (addr)
        ADDR_CR:           reg_cr_o           <= in_sr;
        ADDR_DIRECT:       reg_direct_o       <= in_sr;
        ADDR_4094_OE:      reg_4094_oe_o      <= in_sr;
        ADDR_SA_PRECHARGE: reg_sa_precharge_o <= in_sr;
        ADDR_SA_SEQ_N:     reg_sa_seq_n_o     <= in_sr;
        ADDR_SA_SEQ0:      reg_sa_seq0_o      <= in_sr;
        ADDR_SA_SEQ1:      reg_sa_seq1_o      <= in_sr;
        ADDR_SA_SEQ2:      reg_sa_seq2_o      <= in_sr;
        ADDR_SA_SEQ3:      reg_sa_seq3_o      <= in_sr;
        ADDR_ADC_APERTURE: reg_adc_aperture_o <= in_sr;
        default: begin
        end                                        // status and holes
      endcase
    end
  end

  assign sdo_o = sdo_q & sel_i;   // quiet unless selected

endmodule

// File: sequence_acquisition.sv
// sample-acquisition sequencer over the programmed azmux and precharge entries
`timescale 1ns/1ps

module sequence_acquisition import daq_pkg::*; #(
  parameter int COUNT_W = 24
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       trig_i,               // level, low holds idle
  input  logic       adc_measure_valid_i,
  input  seq_idx_t   seq_n_i,
  input  seq_entry_t seq0_i,
  input  seq_entry_t seq1_i,
  input  seq_entry_t seq2_i,
  input  seq_entry_t seq3_i,
  input  count_t     precharge_i,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic       adc_reset_n_o,
  output seq_idx_t   sample_idx_last_o,
  output logic       first_last_o
);

  sa_state_t          sa_state;
  seq_idx_t           idx;          // current entry
  seq_idx_t           seq_n_eff;
  seq_idx_t           idx_next;
  logic [COUNT_W-1:0] pc_cnt;       // precharge down counter
  seq_entry_t         seq_tab [NUM_SEQ];
  seq_entry_t         entry;

  assign seq_tab[0] = seq0_i;
  assign seq_tab[1] = seq1_i;
  assign seq_tab[2] = seq2_i;
  assign seq_tab[3] = seq3_i;

  // 0 behaves as 1, clamp to the table size
  always_comb begin
    if (seq_n_i == '0) seq_n_eff = 3'd1;
    else if (seq_n_i > seq_idx_t'(NUM_SEQ)) seq_n_eff = seq_idx_t'(NUM_SEQ);
    else seq_n_eff = seq_n_i;
  end

  assign idx_next = (idx + 3'd1 >= seq_n_eff) ? '0 : idx + 3'd1;
  assign entry    = seq_tab[idx[$clog2(NUM_SEQ)-1:0]];

  //////////////////////////////////////////////////////////////////////
  // fsm
  always_ff @(posedge clk_i) begin
    if (rst_i || !trig_i) begin
      sa_state <= IDLE;
      idx      <= '0;
      pc_cnt   <= '0;
    end else begin
      case (sa_state)
        IDLE: begin
          sa_state <= PRECHARGE;
          pc_cnt   <= precharge_i[COUNT_W-1:0];
        end
        PRECHARGE: begin
          if (pc_cnt < COUNT_W'(2)) sa_state <= MEASURE;   // release adc
          else pc_cnt <= pc_cnt - 1'b1;
        end
        MEASURE: begin
          if (adc_measure_valid_i) begin
            idx      <= idx_next;
            sa_state <= ADVANCE;
          end
        end
        ADVANCE: begin               // one clk of adc reset between samples
          sa_state <= PRECHARGE;
          pc_cnt   <= precharge_i[COUNT_W-1:0];
        end
        default: sa_state <= IDLE;
      endcase
    end
  end

  // last completed sample, survives trig low for status readout
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sample_idx_last_o <= '0;
      first_last_o      <= 1'b0;
    end else if (trig_i && sa_state == MEASURE && adc_measure_valid_i) begin
      sample_idx_last_o <= idx;
      first_last_o      <= (idx == '0);
    end
  end

  assign adc_reset_n_o = (sa_state == MEASURE);
  assign azmux_o       = trig_i ? entry[3:0] : 4'b0000;
  assign pc_sw_o       = trig_i ? entry[5:4] : 2'b00;
  assign leds_o        = {trig_i, idx};
  assign monitor_o     = {first_last_o, idx, trig_i, adc_reset_n_o, sa_state};

endmodule

// File: adc_mock.sv
// mock adc timing the aperture and pulsing measure-valid
`timescale 1ns/1ps

module adc_mock import daq_pkg::*; #(
  parameter int COUNT_W = 24
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       reset_n_i,        // from the sequencer
  input  count_t     aperture_i,
  output logic       measure_valid_o,
  output logic [7:0] monitor_o
);

  logic [COUNT_W-1:0] ap_cnt;          // clks integrated so far
  logic               done;            // holds until reset_n drops

  always_ff @(posedge clk_i) begin
    if (rst_i || !reset_n_i) begin
      ap_cnt          <= '0;
      done            <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;         // single clk pulse
      if (!done) begin
        ap_cnt <= ap_cnt + 1'b1;
        if (ap_cnt + 1'b1 >= aperture_i[COUNT_W-1:0]) begin
          measure_valid_o <= 1'b1;
          done            <= 1'b1;
        end
      end
    end
  end

  // low count bits are enough to see it run on a scope
  assign monitor_o = {ap_cnt[4:0], done, measure_valid_o, reset_n_i};

endmodule

// File: mode_mux.sv
// operating-mode selection of the board output pin vector
`timescale 1ns/1ps

module mode_mux import daq_pkg::*; (
  input  mode_t     mode_i,
  input  reg_word_t direct_i,     // direct register
  input  out_vec_t  sa_vec_i,     // sequencer with mock adc
  output out_vec_t  out_o
);

  // pin field map, lsb first
  //   leds        3:0
  //   monitor     11:4
  //   pc_sw       13:12
  //   azmux       17:14
  //   refmux      19:18
  //   rstmux      20
  //   sigmux      21
  //   cmpr latch  22
  //   interrupt   23
  //   spare       25:24

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  out_o = direct_i[$bits(out_vec_t)-1:0];  // raw bit control
      MODE_SA_MOCK: out_o = sa_vec_i;
      default:      out_o = '0;                             // park everything low
    endcase
  end

endmodule

// File: top.sv
// top level with chip-select decode, status word and the mode-muxed pins
`timescale 1ns/1ps

module top import daq_pkg::*; #(
  parameter int COUNT_W = 24
) (
  input  logic       CLK,
  input  logic       rst_i,
  input  logic       SCK,
  input  logic       SDI,
  output logic       SDO,
  input  cs_vec_t    spi_cs_vec,
  input  logic [3:0] hw_flags_i,
  input  logic       spi_glb_miso,
  input  logic       sa_trig_i,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [1:0] adc_refmux_o,
  output logic       adc_sigmux_o,
  output logic       adc_rstmux_o,
  output logic       adc_cmpr_latch_ctl_o,
  output logic       spi_interrupt_ctl_o,
  output logic       spi_glb_mosi,
  output logic       spi_glb_clk,
  output logic       spi_4094_strobe_ctl,
  output logic       spi_4094_oe_ctl,
  output logic       spi_iso_cs,
  output logic       spi_iso_cs2,
  output logic       spi_invert_dac_data,
  output logic       spi_invert_dac_clk,
  output logic       spi_invert_dac_ss
);

  logic       sel_fpga;
  logic       rs_sdo;
  mode_t      mode;
  reg_word_t  reg_cr, reg_direct, reg_4094_oe, reg_status;
  reg_word_t  reg_sa_precharge, reg_sa_seq_n, reg_adc_aperture;
  reg_word_t  reg_sa_seq0, reg_sa_seq1, reg_sa_seq2, reg_sa_seq3;
  logic [1:0] sa_pc_sw;
  logic [3:0] sa_azmux;
  logic [3:0] sa_leds;
  logic [7:0] sa_monitor;
  logic       adc_reset_n;
  seq_idx_t   sa_idx_last;
  logic       sa_first_last;
  logic       mock_valid;
  logic [7:0] mock_monitor;
  out_vec_t   sa_vec;
  out_vec_t   pin_vec;

  //////////////////////////////////////////////////////////////////////
  // spi chip-select decode
  assign sel_fpga            = (spi_cs_vec == CS_FPGA0);
  assign spi_glb_clk         = sel_fpga ? 1'b1 : SCK;   // park high while we talk
  assign spi_glb_mosi        = sel_fpga ? 1'b1 : SDI;
  assign spi_invert_dac_data = spi_glb_mosi;
  assign spi_invert_dac_clk  = spi_glb_clk;
  assign spi_4094_strobe_ctl = (spi_cs_vec == CS_4094);          // active high
  assign spi_invert_dac_ss   = (spi_cs_vec != CS_INVERT_DAC);    // active low
  assign spi_iso_cs          = (spi_cs_vec != CS_MDAC1);         // active low
  assign spi_iso_cs2         = 1'b1;                             // spare select
  assign spi_4094_oe_ctl     = reg_4094_oe[0];

  // downstream devices answer on the shared miso
  assign SDO = rs_sdo | (spi_glb_miso & ~sel_fpga & (spi_cs_vec != CS_DEASSERT));

  assign mode = reg_cr[2:0];

  // readable status
  assign reg_status = {mock_monitor, 1'b0, reg_sa_seq_n[2:0], sa_first_last,
                       sa_idx_last, 4'b0000, hw_flags_i, STATUS_MAGIC};

  register_set u_register_set (
    .clk_i(CLK), .rst_i(rst_i), .sck_i(SCK), .sdi_i(SDI), .sel_i(sel_fpga),
    .reg_status_i(reg_status), .sdo_o(rs_sdo),
    .reg_cr_o(reg_cr), .reg_direct_o(reg_direct), .reg_4094_oe_o(reg_4094_oe),
    .reg_sa_precharge_o(reg_sa_precharge), .reg_sa_seq_n_o(reg_sa_seq_n),
    .reg_sa_seq0_o(reg_sa_seq0), .reg_sa_seq1_o(reg_sa_seq1),
    .reg_sa_seq2_o(reg_sa_seq2), .reg_sa_seq3_o(reg_sa_seq3),
    .reg_adc_aperture_o(reg_adc_aperture)
  );

  //////////////////////////////////////////////////////////////////////
  // sequencer and mock adc
  sequence_acquisition #(.COUNT_W(COUNT_W)) u_sequence_acquisition (
    .clk_i(CLK), .rst_i(rst_i), .trig_i(sa_trig_i),
    .adc_measure_valid_i(mock_valid), .seq_n_i(reg_sa_seq_n[2:0]),
    .seq0_i(reg_sa_seq0[5:0]), .seq1_i(reg_sa_seq1[5:0]),
    .seq2_i(reg_sa_seq2[5:0]), .seq3_i(reg_sa_seq3[5:0]),
    .precharge_i(reg_sa_precharge[23:0]),
    .pc_sw_o(sa_pc_sw), .azmux_o(sa_azmux), .leds_o(sa_leds), .monitor_o(sa_monitor),
    .adc_reset_n_o(adc_reset_n), .sample_idx_last_o(sa_idx_last),
    .first_last_o(sa_first_last)
  );

  adc_mock #(.COUNT_W(COUNT_W)) u_adc_mock (
    .clk_i(CLK), .rst_i(rst_i), .reset_n_i(adc_reset_n),
    .aperture_i(reg_adc_aperture[23:0]),
    .measure_valid_o(mock_valid), .monitor_o(mock_monitor)
  );

  // mode 6 pins, interrupt carries measure valid
  assign sa_vec = {2'b00, mock_valid, 1'b0, 1'b0, 1'b0, 2'b00,
                   sa_azmux, sa_pc_sw, sa_monitor, sa_leds};

  mode_mux u_mode_mux (
    .mode_i(mode), .direct_i(reg_direct), .sa_vec_i(sa_vec), .out_o(pin_vec)
  );

  assign {spi_interrupt_ctl_o, adc_cmpr_latch_ctl_o, adc_sigmux_o, adc_rstmux_o,
          adc_refmux_o, azmux_o, pc_sw_o, monitor_o, leds_o} = pin_vec[23:0];

endmodule

// File: top_asserts.sv
// concurrent checks on the chip-select decode and the muxed switch pins
`timescale 1ns/1ps

module top_asserts import daq_pkg::*; (
  input logic       clk_i,
  input logic       rst_i,
  input cs_vec_t    cs_vec_i,     // board select vector
  input mode_t      mode_i,       // cr[2:0]
  input logic       iso_cs2_i,
  input logic       glb_clk_i,
  input logic [3:0] azmux_i,
  input logic [1:0] pc_sw_i
);

  // spare isolated select never used
  iso_cs2_high: assert property (@(posedge clk_i) disable iff (rst_i) iso_cs2_i)
    else $error("spi_iso_cs2 went low");

  // shared sck parked while the fpga itself is addressed
  glb_clk_parked: assert property (@(posedge clk_i) disable iff (rst_i)
    (cs_vec_i == CS_FPGA0) |-> glb_clk_i)
    else $error("spi_glb_clk low while CS_FPGA0 selected");

  // unused modes keep the analog switches open
  switches_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mode_i == MODE_DIRECT || mode_i == MODE_SA_MOCK) |-> (azmux_i == '0 && pc_sw_i == '0))
    else $error("azmux or pc_sw driven in an unused mode");

endmodule

// File: tb_top.sv
// testbench with clock, reset, stim-file driven spi frames and pin checks
`timescale 1ns/1ps

module tb_top import daq_pkg::*; ();

  localparam int HALF_SCK   = 8;      // clk per sck half period
  localparam int WAIT_LIMIT = 2000;   // clk budget per pulse wait

  logic       CLK, rst_i, SCK, SDI, SDO;
  cs_vec_t    spi_cs_vec;
  logic [3:0] hw_flags;
  logic       spi_glb_miso, sa_trig;
  logic [3:0] leds_o, azmux_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o, adc_refmux_o;
  logic       adc_sigmux_o, adc_rstmux_o, adc_cmpr_latch_ctl_o, spi_interrupt_ctl_o;
  logic       spi_glb_mosi, spi_glb_clk, spi_4094_strobe_ctl, spi_4094_oe_ctl;
  logic       spi_iso_cs, spi_iso_cs2, spi_invert_dac_data, spi_invert_dac_clk;
  logic       spi_invert_dac_ss;

  int          check_errs;   // wrong values
  int          misc_errs;    // timeouts, bad stim
  int          fd;
  int          nf;
  string       line;

  top #(.COUNT_W(24)) UUT (
    .CLK(CLK), .rst_i(rst_i), .SCK(SCK), .SDI(SDI), .SDO(SDO), .spi_cs_vec(spi_cs_vec),
    .hw_flags_i(hw_flags), .spi_glb_miso(spi_glb_miso), .sa_trig_i(sa_trig),
    .leds_o(leds_o), .monitor_o(monitor_o), .pc_sw_o(pc_sw_o), .azmux_o(azmux_o),
    .adc_refmux_o(adc_refmux_o), .adc_sigmux_o(adc_sigmux_o), .adc_rstmux_o(adc_rstmux_o),
    .adc_cmpr_latch_ctl_o(adc_cmpr_latch_ctl_o), .spi_interrupt_ctl_o(spi_interrupt_ctl_o),
    .spi_glb_mosi(spi_glb_mosi), .spi_glb_clk(spi_glb_clk),
    .spi_4094_strobe_ctl(spi_4094_strobe_ctl), .spi_4094_oe_ctl(spi_4094_oe_ctl),
    .spi_iso_cs(spi_iso_cs), .spi_iso_cs2(spi_iso_cs2),
    .spi_invert_dac_data(spi_invert_dac_data), .spi_invert_dac_clk(spi_invert_dac_clk),
    .spi_invert_dac_ss(spi_invert_dac_ss)
  );

  bind top top_asserts u_top_asserts (
    .clk_i(CLK), .rst_i(rst_i), .cs_vec_i(spi_cs_vec), .mode_i(mode),
    .iso_cs2_i(spi_iso_cs2), .glb_clk_i(spi_glb_clk), .azmux_i(azmux_o), .pc_sw_i(pc_sw_o)
  );

  always #50 CLK = ~CLK;   // 100 ns

  //////////////////////////////////////////////////////////////////////
  // helpers
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      check_errs++;
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) @(negedge CLK);
  endtask

  // mode-muxed pins by the field map, oe pin on top
  function automatic logic [24:0] pin_vector();
    return {spi_4094_oe_ctl, spi_interrupt_ctl_o, adc_cmpr_latch_ctl_o, adc_sigmux_o,
            adc_rstmux_o, adc_refmux_o, azmux_o, pc_sw_o, monitor_o, leds_o};
  endfunction

  // one 40-bit mode 0 frame, miso sampled before each rising sck
  task automatic spi_frame(input logic wr, input reg_addr_t addr, input reg_word_t wdata,
                           output reg_word_t rdata);
    logic [39:0] frame;
    frame = {wr, addr, wdata};
    rdata = '0;
    @(negedge CLK);
    spi_cs_vec = CS_FPGA0;
    idle_cycles(HALF_SCK);            // let select through the synchronizer
    for (int i = 0; i < 40; i++) begin
      SCK = 1'b0;
      SDI = frame[39-i];
      idle_cycles(HALF_SCK);
      if (i >= 8) rdata[39-i] = SDO;  // data phase only
      SCK = 1'b1;
      idle_cycles(HALF_SCK);
    end
    SCK = 1'b0;
    idle_cycles(HALF_SCK);
    spi_cs_vec = CS_DEASSERT;
    SDI = 1'b0;
    idle_cycles(HALF_SCK);            // commit lands within 4 clk
  endtask

  // select pins for one cs code, then sck passthrough both levels
  task automatic decode_check(input cs_vec_t cs, input logic strobe, input logic dac_ss,
                              input logic iso_cs);
    logic exp_clk;
    logic exp_mosi;
    @(negedge CLK);
    spi_cs_vec = cs;
    SCK = 1'b0;
    SDI = 1'b0;
    @(negedge CLK);
    check_value("spi_4094_strobe_ctl", spi_4094_strobe_ctl, strobe);
    check_value("spi_invert_dac_ss", spi_invert_dac_ss, dac_ss);
    check_value("spi_iso_cs", spi_iso_cs, iso_cs);
    check_value("spi_iso_cs2", spi_iso_cs2, 1'b1);
    for (int s = 0; s < 2; s++) begin
      SCK = s[0];
      SDI = ~s[0];                                 // opposite of sck
      @(negedge CLK);
      exp_clk  = (cs == CS_FPGA0) ? 1'b1 : s[0];   // parked high for our own frames
      exp_mosi = (cs == CS_FPGA0) ? 1'b1 : ~s[0];
      check_value("spi_glb_clk", spi_glb_clk, exp_clk);
      check_value("spi_glb_mosi", spi_glb_mosi, exp_mosi);
      check_value("spi_invert_dac_clk", spi_invert_dac_clk, exp_clk);
      check_value("spi_invert_dac_data", spi_invert_dac_data, exp_mosi);
    end
    SCK = 1'b0;
    SDI = 1'b0;
    @(negedge CLK);
    spi_cs_vec = CS_DEASSERT;
  endtask

  // next interrupt pulse, switch state taken in the pulse cycle
  task automatic wait_interrupt(input logic [5:0] exp_pc_az);
    int  n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
      @(negedge CLK);
      if (spi_interrupt_ctl_o) seen = 1'b1;
    end
    if (seen) begin
      check_value("{pc_sw_o, azmux_o}", {pc_sw_o, azmux_o}, exp_pc_az);
    end else begin
      $display("timeout at %0t: no interrupt pulse within %0d cycles", $time, WAIT_LIMIT);
      misc_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one stim line
  task automatic run_op(input string text);
    logic [7:0]  op;
    logic [31:0] a, b, c, d;
    int          cnt;
    reg_word_t   rd;
    reg_word_t   rnd;
    a = '0;
    b = '0;
    c = '0;
    d = '0;
    cnt = $sscanf(text, "%c %h %h %h %h", op, a, b, c, d);
    case (op)
      "w": spi_frame(1'b1, a[6:0], b, rd);
      "r": begin
        spi_frame(1'b0, a[6:0], '0, rd);
        check_value($sformatf("reg[%0h] masked %h", a[6:0], c), rd & c, b & c);
      end
      "x": begin                        // random word, read back
        rnd = $urandom;
        spi_frame(1'b1, a[6:0], rnd, rd);
        spi_frame(1'b0, a[6:0], '0, rd);
        check_value($sformatf("reg[%0h]", a[6:0]), rd, rnd);
      end
      "c": decode_check(a[2:0], b[0], c[0], d[0]);
      "f": begin
        @(negedge CLK);
        hw_flags = a[3:0];
      end
      "t": begin
        @(negedge CLK);
        sa_trig = a[0];
      end
      "p": begin
        @(negedge CLK);
        check_value("pin vector", pin_vector() & b[24:0], a[24:0] & b[24:0]);
      end
      "v": wait_interrupt(a[5:0]);
      "n": idle_cycles(a);
      default: begin
        $display("unknown stim operation in line: %s (%0d fields)", text, cnt);
        misc_errs++;
      end
    endcase
  endtask

  initial begin
    void'($urandom(49287));
    CLK          = 1'b0;
    rst_i        = 1'b1;
    SCK          = 1'b0;
    SDI          = 1'b0;
    spi_cs_vec   = CS_DEASSERT;
    hw_flags     = 4'h0;
    spi_glb_miso = 1'b0;
    sa_trig      = 1'b0;
    check_errs   = 0;
    misc_errs    = 0;
    idle_cycles(10);
    rst_i = 1'b0;

    fd = $fopen("tb_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tb_stim.txt");
      misc_errs++;
    end else begin
      while (!$feof(fd)) begin
        nf = $fgets(line, fd);
        if (nf > 0 && line.len() > 1 && line[0] != "#") run_op(line);
      end
      $fclose(fd);
    end

    $display("errors: %0d value checks, %0d other", check_errs, misc_errs);
    if (check_errs == 0 && misc_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
daq_pkg.sv
register_set.sv
sequence_acquisition.sv
adc_mock.sv
mode_mux.sv
top.sv
top_asserts.sv
tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator, result from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module tb_top -Mdir obj_dir -o Vtb_top

status=0
./obj_dir/Vtb_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TESTBENCH PASSED" sim.log; then
  exit 1
fi

// File: tb_stim.txt
# op fields in hex: w addr data | r addr expect mask | x addr (random write, read back)
# c cs strobe dac_ss iso_cs | f flags | t trig | p expect mask | v pc_az | n cycles
f 5
r 3 000005aa 00000fff
r 0 00000000 ffffffff
x 1
x 4
x 6
x 7
x 8
x 9
x a
w 3 12345678
r 3 000005aa 00000fff
r 5 00000000 ffffffff
w 1 00abcdef
p 00abcdef 00ffffff
w 2 00000001
p 01000000 01000000
w 2 fffffffe
p 00000000 01000000
c 0 0 1 1
c 1 0 1 1
c 2 1 1 1
c 3 0 0 1
c 4 0 1 0
c 7 0 1 1
w 4 00000005
w a 00000008
w 6 00000015
w 7 0000002a
w 8 00000033
w 9 0000000f
w 5 00000003
w 0 00000006
t 1
v 15
v 2a
v 33
v 15
v 2a
t 0
r 3 003105aa 007f0fff
w 0 00000003
t 1
n 50
p 00000000 00ffffff
t 0
